/* mips_ex_params.svh */
`ifndef MIPS_EX_PARAMS_SVH
`define MIPS_EX_PARAMS_SVH

// datapath width
`define MIPS_NB_DATA 32

// register file address
`define MIPS_NB_REG 5

// opcode and function fields share one width
`define MIPS_NB_OP 6

`define MIPS_NB_SHAMT 5     // shift amount field

`define MIPS_NB_WIDTH 2     // memory access width code

`endif

/* mips_ex_pkg.sv */
`include "mips_ex_params.svh"

package mips_ex_pkg;

    // alu operations, function field codes first, then opcode codes
    typedef enum logic [`MIPS_NB_OP-1:0] {
        ALU_SLL   = 6'b000000,
        ALU_SRL   = 6'b000010,
        ALU_SRA   = 6'b000011,
        ALU_SLLV  = 6'b000100,
        ALU_SRLV  = 6'b000110,
        ALU_SRAV  = 6'b000111,
        ALU_ADD   = 6'b100000,
        ALU_ADDU  = 6'b100001,
        ALU_SUB   = 6'b100010,
        ALU_SUBU  = 6'b100011,
        ALU_AND   = 6'b100100,
        ALU_OR    = 6'b100101,
        ALU_XOR   = 6'b100110,
        ALU_NOR   = 6'b100111,
        ALU_SLT   = 6'b101010,
        ALU_SLTU  = 6'b101011,
        ALU_ADDI  = 6'b001000,
        ALU_ADDIU = 6'b001001,   // same code as JALR in the function field
        ALU_SLTI  = 6'b001010,
        ALU_ANDI  = 6'b001100,
        ALU_ORI   = 6'b001101,
        ALU_XORI  = 6'b001110,
        ALU_LUI   = 6'b001111,
        ALU_IDLE  = 6'b111111
    } alu_op_e;

    // raw field codes of the link instructions
    // JAL shares its code with SRA, JALR with ADDIU
    localparam logic [`MIPS_NB_OP-1:0] OPC_RTYPE = 6'b000000;
    localparam logic [`MIPS_NB_OP-1:0] OPC_JAL   = 6'b000011;
    localparam logic [`MIPS_NB_OP-1:0] FUNC_JALR = 6'b001001;

    typedef enum logic [1:0] {
        LOAD_STORE = 2'b00,
        BRANCH     = 2'b01,
        R_TYPE     = 2'b10,
        I_TYPE     = 2'b11
    } alu_class_e;

    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,      // register file value
        FWD_MEMWB = 2'b10,
        FWD_EXMEM = 2'b11
    } fwd_sel_e;

    // decode control bits into EX
    typedef struct packed {
        logic                        reg_dst;
        logic                        mem2reg;
        logic                        mem_read;
        logic                        mem_write;
        logic                        imm_flag;
        logic                        reg_write;
        alu_class_e                  alu_class;
        logic [`MIPS_NB_WIDTH-1:0]   width;
        logic                        sign_flag;
    } ex_ctrl_t;

    // EX/MEM register contents
    typedef struct packed {
        logic                        mem2reg;
        logic                        mem_write;
        logic                        reg_write;
        logic [`MIPS_NB_WIDTH-1:0]   width;
        logic                        sign_flag;
        logic [`MIPS_NB_REG-1:0]     write_reg;
        logic [`MIPS_NB_DATA-1:0]    data4mem;
        logic [`MIPS_NB_DATA-1:0]    result;
    } ex_mem_t;

endpackage

/* alu.sv */
`timescale 1ns/1ps
`include "mips_ex_params.svh"

module alu (
    input  mips_ex_pkg::alu_op_e         i_op,
    input  logic [`MIPS_NB_DATA-1:0]     i_data_a,
    input  logic [`MIPS_NB_DATA-1:0]     i_data_b,
    input  logic [`MIPS_NB_SHAMT-1:0]    i_shamt,
    output logic [`MIPS_NB_DATA-1:0]     o_result
);

    logic [`MIPS_NB_SHAMT-1:0] var_shamt;    // variable shifts use low bits of A
    logic                      lt_signed;
    logic                      lt_unsigned;

    assign var_shamt   = i_data_a[`MIPS_NB_SHAMT-1:0];
    assign lt_signed   = $signed(i_data_a) < $signed(i_data_b);
    assign lt_unsigned = i_data_a < i_data_b;

    always_comb begin
        case (i_op)
            // addu/addiu also cover jalr and the link address sum
            mips_ex_pkg::ALU_ADD,
            mips_ex_pkg::ALU_ADDU,
            mips_ex_pkg::ALU_ADDI,
            mips_ex_pkg::ALU_ADDIU: begin
                o_result = i_data_a + i_data_b;
            end
            mips_ex_pkg::ALU_SUB,
            mips_ex_pkg::ALU_SUBU: begin
                o_result = i_data_a - i_data_b;
            end
            mips_ex_pkg::ALU_AND,
            mips_ex_pkg::ALU_ANDI: begin
                o_result = i_data_a & i_data_b;
            end
            mips_ex_pkg::ALU_OR,
            mips_ex_pkg::ALU_ORI: begin
                o_result = i_data_a | i_data_b;
            end
            mips_ex_pkg::ALU_XOR,
            mips_ex_pkg::ALU_XORI: begin
                o_result = i_data_a ^ i_data_b;
            end
            mips_ex_pkg::ALU_NOR: o_result = ~(i_data_a | i_data_b);
            mips_ex_pkg::ALU_SLT,
            mips_ex_pkg::ALU_SLTI: begin
                o_result = {{(`MIPS_NB_DATA-1){1'b0}}, lt_signed};
            end
            mips_ex_pkg::ALU_SLTU: begin
                o_result = {{(`MIPS_NB_DATA-1){1'b0}}, lt_unsigned};
            end
            // shifts act on B (rt)
            mips_ex_pkg::ALU_SLL:  o_result = i_data_b << i_shamt;
            mips_ex_pkg::ALU_SRL:  o_result = i_data_b >> i_shamt;
            mips_ex_pkg::ALU_SRA:  o_result = $signed(i_data_b) >>> i_shamt;
            mips_ex_pkg::ALU_SLLV: o_result = i_data_b << var_shamt;
            mips_ex_pkg::ALU_SRLV: o_result = i_data_b >> var_shamt;
            mips_ex_pkg::ALU_SRAV: o_result = $signed(i_data_b) >>> var_shamt;
            mips_ex_pkg::ALU_LUI:  o_result = i_data_b << 16;   // immediate to upper half
            default:               o_result = '0;               // idle and unknown codes
        endcase
    end

endmodule

/* forwarding_unit.sv */
`timescale 1ns/1ps
`include "mips_ex_params.svh"

module forwarding_unit (
    input  logic [`MIPS_NB_REG-1:0]   i_rs,
    input  logic [`MIPS_NB_REG-1:0]   i_rt,
    input  logic                      i_exmem_reg_write,
    input  logic [`MIPS_NB_REG-1:0]   i_exmem_write_reg,
    input  logic                      i_memwb_reg_write,
    input  logic [`MIPS_NB_REG-1:0]   i_memwb_write_reg,
    output mips_ex_pkg::fwd_sel_e     o_fw_a,
    output mips_ex_pkg::fwd_sel_e     o_fw_b
);

    logic exmem_valid;
    logic memwb_valid;

    // r0 is hardwired, never a forwarding source
    assign exmem_valid = i_exmem_reg_write && (i_exmem_write_reg != '0);
    assign memwb_valid = i_memwb_reg_write && (i_memwb_write_reg != '0);

    // youngest result wins
    always_comb begin
        if (exmem_valid && (i_exmem_write_reg == i_rs)) begin
            o_fw_a = mips_ex_pkg::FWD_EXMEM;
        end else if (memwb_valid && (i_memwb_write_reg == i_rs)) begin
            o_fw_a = mips_ex_pkg::FWD_MEMWB;
        end else begin
            o_fw_a = mips_ex_pkg::FWD_REG;
        end
    end

    always_comb begin
        if (exmem_valid && (i_exmem_write_reg == i_rt)) begin
            o_fw_b = mips_ex_pkg::FWD_EXMEM;
        end else if (memwb_valid && (i_memwb_write_reg == i_rt)) begin
            o_fw_b = mips_ex_pkg::FWD_MEMWB;
        end else begin
            o_fw_b = mips_ex_pkg::FWD_REG;
        end
    end

endmodule

/* ex_mem_reg.sv */
`timescale 1ns/1ps
`include "mips_ex_params.svh"

module ex_mem_reg (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_halt,
    input  mips_ex_pkg::ex_ctrl_t       i_ctrl,
    input  logic [`MIPS_NB_REG-1:0]     i_rt,
    input  logic [`MIPS_NB_REG-1:0]     i_rd,
    input  logic [`MIPS_NB_DATA-1:0]    i_result,
    input  logic [`MIPS_NB_DATA-1:0]    i_data4mem,     // store data for sw/sh/sb
    output mips_ex_pkg::ex_mem_t        o_ex_mem
);

    mips_ex_pkg::ex_mem_t     ex_mem_next;
    mips_ex_pkg::ex_mem_t     ex_mem_q;
    logic [`MIPS_NB_REG-1:0]  write_reg;

    // R-type writes rd, immediate and load forms write rt
    assign write_reg = i_ctrl.reg_dst ? i_rd : i_rt;

    always_comb begin
        ex_mem_next.mem2reg   = i_ctrl.mem2reg;
        ex_mem_next.mem_write = i_ctrl.mem_write;
        ex_mem_next.reg_write = i_ctrl.reg_write;
        ex_mem_next.width     = i_ctrl.width;
        ex_mem_next.sign_flag = i_ctrl.sign_flag;
        ex_mem_next.write_reg = write_reg;
        ex_mem_next.data4mem  = i_data4mem;
        ex_mem_next.result    = i_result;
    end

    // reset beats halt
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ex_mem_q <= '0;
        end else if (!i_halt) begin
            ex_mem_q <= ex_mem_next;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps
`include "mips_ex_params.svh"

module ex_stage (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_halt,
    input  logic [`MIPS_NB_REG-1:0]     i_rt,
    input  logic [`MIPS_NB_REG-1:0]     i_rd,
    input  logic [`MIPS_NB_DATA-1:0]    i_reg_da,
    input  logic [`MIPS_NB_DATA-1:0]    i_reg_db,
    input  logic [`MIPS_NB_DATA-1:0]    i_immediate,
    input  logic [`MIPS_NB_OP-1:0]      i_opcode,
    input  logic [`MIPS_NB_SHAMT-1:0]   i_shamt,
    input  logic [`MIPS_NB_OP-1:0]      i_func,
    input  mips_ex_pkg::ex_ctrl_t       i_ctrl,
    input  mips_ex_pkg::fwd_sel_e       i_fw_a,
    input  mips_ex_pkg::fwd_sel_e       i_fw_b,
    input  logic [`MIPS_NB_DATA-1:0]    i_result_memwb,    // writeback value
    input  logic [`MIPS_NB_DATA-1:0]    i_result_exmem,    // our own registered result
    output mips_ex_pkg::ex_mem_t        o_ex_mem
);

    mips_ex_pkg::alu_op_e        alu_op;
    logic                        is_link;
    logic [`MIPS_NB_DATA-1:0]    data_a;
    logic [`MIPS_NB_DATA-1:0]    data_b;
    logic [`MIPS_NB_DATA-1:0]    data4mem;
    logic [`MIPS_NB_DATA-1:0]    alu_result;

    // jal, or jalr in the function field
    assign is_link = (i_opcode == mips_ex_pkg::OPC_JAL) ||
                     ((i_opcode == mips_ex_pkg::OPC_RTYPE) &&
                      (i_func == mips_ex_pkg::FUNC_JALR));

    always_comb begin
        case (i_ctrl.alu_class)
            mips_ex_pkg::LOAD_STORE: alu_op = mips_ex_pkg::ALU_ADD;    // base + offset
            mips_ex_pkg::BRANCH:     alu_op = mips_ex_pkg::ALU_IDLE;
            mips_ex_pkg::R_TYPE:     alu_op = mips_ex_pkg::alu_op_e'(i_func);
            mips_ex_pkg::I_TYPE: begin
                // jal opcode would decode as sra otherwise
                if (i_opcode == mips_ex_pkg::OPC_JAL) begin
                    alu_op = mips_ex_pkg::ALU_ADD;
                end else begin
                    alu_op = mips_ex_pkg::alu_op_e'(i_opcode);
                end
            end
            default:                 alu_op = mips_ex_pkg::ALU_IDLE;
        endcase
    end

    // operand A, link instructions skip forwarding
    always_comb begin
        case (i_fw_a)
            mips_ex_pkg::FWD_REG:   data_a = i_reg_da;
            mips_ex_pkg::FWD_MEMWB: data_a = i_result_memwb;
            mips_ex_pkg::FWD_EXMEM: data_a = i_result_exmem;
            default:                data_a = '0;
        endcase
        if (is_link) begin
            data_a = i_reg_da;
        end
    end

    // operand B, store data taken before the link and immediate overrides
    always_comb begin
        case (i_fw_b)
            mips_ex_pkg::FWD_REG:   data_b = i_reg_db;
            mips_ex_pkg::FWD_MEMWB: data_b = i_result_memwb;
            mips_ex_pkg::FWD_EXMEM: data_b = i_result_exmem;
            default:                data_b = '0;
        endcase
        data4mem = data_b;
        if (is_link) begin
            data_b = i_reg_db;
        end
        if (i_ctrl.imm_flag) begin
            data_b = i_immediate;
        end
    end

    alu u_alu (
        .i_op       (alu_op),
        .i_data_a   (data_a),
        .i_data_b   (data_b),
        .i_shamt    (i_shamt),
        .o_result   (alu_result)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_halt     (i_halt),
        .i_ctrl     (i_ctrl),
        .i_rt       (i_rt),
        .i_rd       (i_rd),
        .i_result   (alu_result),
        .i_data4mem (data4mem),
        .o_ex_mem   (o_ex_mem)
    );

endmodule

/* ex_subsystem.sv */
`timescale 1ns/1ps
`include "mips_ex_params.svh"

module ex_subsystem (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_halt,
    input  logic [`MIPS_NB_REG-1:0]     i_rs,
    input  logic [`MIPS_NB_REG-1:0]     i_rt,
    input  logic [`MIPS_NB_REG-1:0]     i_rd,
    input  logic [`MIPS_NB_DATA-1:0]    i_reg_da,
    input  logic [`MIPS_NB_DATA-1:0]    i_reg_db,
    input  logic [`MIPS_NB_DATA-1:0]    i_immediate,
    input  logic [`MIPS_NB_OP-1:0]      i_opcode,
    input  logic [`MIPS_NB_SHAMT-1:0]   i_shamt,
    input  logic [`MIPS_NB_OP-1:0]      i_func,
    input  mips_ex_pkg::ex_ctrl_t       i_ctrl,
    input  logic                        i_memwb_reg_write,
    input  logic [`MIPS_NB_REG-1:0]     i_memwb_write_reg,
    input  logic [`MIPS_NB_DATA-1:0]    i_memwb_result,
    output mips_ex_pkg::ex_mem_t        o_ex_mem
);

    mips_ex_pkg::ex_mem_t    ex_mem;    // fed back for forwarding
    mips_ex_pkg::fwd_sel_e   fw_a;
    mips_ex_pkg::fwd_sel_e   fw_b;

    forwarding_unit u_forwarding_unit (
        .i_rs               (i_rs),
        .i_rt               (i_rt),
        .i_exmem_reg_write  (ex_mem.reg_write),
        .i_exmem_write_reg  (ex_mem.write_reg),
        .i_memwb_reg_write  (i_memwb_reg_write),
        .i_memwb_write_reg  (i_memwb_write_reg),
        .o_fw_a             (fw_a),
        .o_fw_b             (fw_b)
    );

    ex_stage u_ex_stage (
        .clk                (clk),
        .i_reset            (i_reset),
        .i_halt             (i_halt),
        .i_rt               (i_rt),
        .i_rd               (i_rd),
        .i_reg_da           (i_reg_da),
        .i_reg_db           (i_reg_db),
        .i_immediate        (i_immediate),
        .i_opcode           (i_opcode),
        .i_shamt            (i_shamt),
        .i_func             (i_func),
        .i_ctrl             (i_ctrl),
        .i_fw_a             (fw_a),
        .i_fw_b             (fw_b),
        .i_result_memwb     (i_memwb_result),
        .i_result_exmem     (ex_mem.result),
        .o_ex_mem           (ex_mem)
    );

    assign o_ex_mem = ex_mem;

endmodule

/* ex_subsystem_checker.sv */
`timescale 1ns/1ps

module ex_subsystem_checker (
    input logic                    clk,
    input logic                    i_reset,
    input logic                    i_halt,
    input mips_ex_pkg::ex_mem_t    i_ex_mem
);

    int unsigned fail_count = 0;    // assertion failures so far

    // reset leaves no pending memory or register write
    a_reset_clears: assert property (@(posedge clk)
        i_reset |=> (!i_ex_mem.reg_write && !i_ex_mem.mem_write))
    else begin
        $error("write enables still set after reset");
        fail_count++;
    end

    // halt freezes the whole EX/MEM register
    a_halt_holds: assert property (@(posedge clk) disable iff (i_reset)
        i_halt |=> $stable(i_ex_mem))
    else begin
        $error("EX/MEM register changed while halted");
        fail_count++;
    end

    // a dropped write must not look like a load result
    a_no_write_no_load: assert property (@(posedge clk) disable iff (i_reset)
        (!i_ex_mem.reg_write && (i_ex_mem.write_reg != '0)) |-> !i_ex_mem.mem2reg)
    else begin
        $error("load result with register write disabled");
        fail_count++;
    end

endmodule

bind ex_subsystem ex_subsystem_checker u_checker (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_halt     (i_halt),
    .i_ex_mem   (o_ex_mem)
);

/* tb_ex_subsystem.sv */
`timescale 1ns/1ps
`include "mips_ex_params.svh"

module tb_ex_subsystem;

    localparam int REPS = 40;
    // reset plus 24 instructions per rep plus the fixed tests, doubled
    localparam int TIMEOUT_CYCLES = 2 * (10 + 24 * REPS + 40);

    logic clk = 1'b0;
    logic i_reset;
    logic i_halt;
    logic [`MIPS_NB_REG-1:0] i_rs;
    logic [`MIPS_NB_REG-1:0] i_rt;
    logic [`MIPS_NB_REG-1:0] i_rd;
    logic [`MIPS_NB_REG-1:0] i_memwb_write_reg;
    logic [`MIPS_NB_DATA-1:0] i_reg_da;
    logic [`MIPS_NB_DATA-1:0] i_reg_db;
    logic [`MIPS_NB_DATA-1:0] i_immediate;
    logic [`MIPS_NB_DATA-1:0] i_memwb_result;
    logic [`MIPS_NB_OP-1:0] i_opcode;
    logic [`MIPS_NB_OP-1:0] i_func;
    logic [`MIPS_NB_SHAMT-1:0] i_shamt;
    logic i_memwb_reg_write;
    mips_ex_pkg::ex_ctrl_t i_ctrl;
    mips_ex_pkg::ex_mem_t o_ex_mem;
    mips_ex_pkg::ex_mem_t prev_exp;     // what EX/MEM should hold now
    integer seed = 40154;
    int cycle_count = 0;
    int total_checks = 0;
    int total_errors = 0;
    int test_checks = 0;
    int test_errors = 0;
    int unsigned afails;

    always #2 clk = ~clk;

    ex_subsystem DUT (
        .clk(clk), .i_reset(i_reset), .i_halt(i_halt), .i_rs(i_rs), .i_rt(i_rt), .i_rd(i_rd),
        .i_reg_da(i_reg_da), .i_reg_db(i_reg_db), .i_immediate(i_immediate),
        .i_opcode(i_opcode), .i_shamt(i_shamt), .i_func(i_func), .i_ctrl(i_ctrl),
        .i_memwb_reg_write(i_memwb_reg_write), .i_memwb_write_reg(i_memwb_write_reg),
        .i_memwb_result(i_memwb_result), .o_ex_mem(o_ex_mem)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic mips_ex_pkg::ex_ctrl_t make_ctrl(input logic reg_dst,
            input logic mem2reg, input logic mem_read, input logic mem_write,
            input logic imm_flag, input logic reg_write, input mips_ex_pkg::alu_class_e cls,
            input logic [1:0] width, input logic sign_flag);
        return {reg_dst, mem2reg, mem_read, mem_write, imm_flag, reg_write, cls, width,
                sign_flag};
    endfunction

    function automatic logic [31:0] shift_arith(input logic [31:0] v, input logic [4:0] n);
        return (v >> n) | (~(32'hffff_ffff >> n) & {32{v[31]}});
    endfunction

    // ISA semantics by raw field code
    function automatic logic [31:0] alu_model(input logic [5:0] op, input logic [31:0] a,
            input logic [31:0] b, input logic [4:0] sh);
        case (op)
            6'b100000, 6'b100001, 6'b001000, 6'b001001: return a + b;  // jalr too
            6'b100010, 6'b100011: return a + ~b + 32'd1;
            6'b100100, 6'b001100: return a & b;
            6'b100101, 6'b001101: return a | b;
            6'b100110, 6'b001110: return a ^ b;
            6'b100111: return ~a & ~b;
            6'b101010, 6'b001010: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            6'b101011: return {31'b0, a < b};
            6'b000000: return b << sh;
            6'b000010: return b >> sh;
            6'b000011: return shift_arith(b, sh);
            6'b000100: return b << a[4:0];
            6'b000110: return b >> a[4:0];
            6'b000111: return shift_arith(b, a[4:0]);
            6'b001111: return {b[15:0], 16'h0000};
            default:   return 32'h0;
        endcase
    endfunction

    // EX/MEM beats MEM/WB and r0 is never forwarded
    function automatic logic [31:0] operand_source(input logic [4:0] r, input logic [31:0] v);
        if (prev_exp.reg_write && (prev_exp.write_reg != '0) && (prev_exp.write_reg == r)) begin
            return prev_exp.result;
        end else if (i_memwb_reg_write && (i_memwb_write_reg != '0) &&
                     (i_memwb_write_reg == r)) begin
            return i_memwb_result;
        end
        return v;
    endfunction

    function automatic mips_ex_pkg::ex_mem_t model_next();
        mips_ex_pkg::ex_mem_t e;
        logic link;
        logic [5:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] store;
        link = (i_opcode == 6'b000011) || ((i_opcode == 6'b000000) && (i_func == 6'b001001));
        a = link ? i_reg_da : operand_source(i_rs, i_reg_da);
        store = operand_source(i_rt, i_reg_db);
        b = link ? i_reg_db : store;
        if (i_ctrl.imm_flag) b = i_immediate;
        case (i_ctrl.alu_class)
            mips_ex_pkg::LOAD_STORE: op = 6'b100000;
            mips_ex_pkg::BRANCH:     op = 6'b111111;
            mips_ex_pkg::R_TYPE:     op = i_func;
            default:                 op = (i_opcode == 6'b000011) ? 6'b100000 : i_opcode;
        endcase
        e.mem2reg   = i_ctrl.mem2reg;
        e.mem_write = i_ctrl.mem_write;
        e.reg_write = i_ctrl.reg_write;
        e.width     = i_ctrl.width;
        e.sign_flag = i_ctrl.sign_flag;
        e.write_reg = i_ctrl.reg_dst ? i_rd : i_rt;
        e.data4mem  = store;
        e.result    = alu_model(op, a, b, i_shamt);
        return e;
    endfunction

    // one instruction through the register and checked at the next falling edge
    task automatic step(input string name);
        mips_ex_pkg::ex_mem_t exp;
        if (i_reset) exp = '0;
        else if (i_halt) exp = prev_exp;
        else exp = model_next();
        @(posedge clk);
        @(negedge clk);
        test_checks++;
        total_checks++;
        if (o_ex_mem !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, o_ex_mem);
            test_errors++;
            total_errors++;
        end
        prev_exp = exp;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        total_checks++;
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic drive_add(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
            input logic [31:0] da, input logic [31:0] db);
        i_rs = rs;
        i_rt = rt;
        i_rd = rd;
        i_reg_da = da;
        i_reg_db = db;
        i_immediate = '0;
        i_shamt = '0;
        i_opcode = 6'b000000;
        i_func = 6'b100000;
        i_ctrl = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, mips_ex_pkg::R_TYPE, 2'b00, 1'b0);
    endtask

    task automatic r_type_ops();
        logic [5:0] ops [16];
        logic [31:0] r;
        ops = '{mips_ex_pkg::ALU_SLL, mips_ex_pkg::ALU_SRL, mips_ex_pkg::ALU_SRA,
                mips_ex_pkg::ALU_SLLV, mips_ex_pkg::ALU_SRLV, mips_ex_pkg::ALU_SRAV,
                mips_ex_pkg::ALU_ADD, mips_ex_pkg::ALU_ADDU, mips_ex_pkg::ALU_SUB,
                mips_ex_pkg::ALU_SUBU, mips_ex_pkg::ALU_AND, mips_ex_pkg::ALU_OR,
                mips_ex_pkg::ALU_XOR, mips_ex_pkg::ALU_NOR, mips_ex_pkg::ALU_SLT,
                mips_ex_pkg::ALU_SLTU};
        for (int rep = 0; rep < REPS; rep++) begin
            for (int k = 0; k < 16; k++) begin
                r = $random(seed);
                drive_add(r[4:0], r[9:5], (r[14:10] == '0) ? 5'd1 : r[14:10],
                          $random(seed), $random(seed));
                i_shamt = r[19:15];
                i_func = ops[k];
                step("r_type");
            end
        end
        end_test("r_type");
    endtask

    task automatic i_type_imm();
        logic [5:0] ops [6];
        logic [31:0] r;
        ops = '{mips_ex_pkg::ALU_ADDI, mips_ex_pkg::ALU_ANDI, mips_ex_pkg::ALU_ORI,
                mips_ex_pkg::ALU_XORI, mips_ex_pkg::ALU_SLTI, mips_ex_pkg::ALU_LUI};
        for (int rep = 0; rep < REPS; rep++) begin
            for (int k = 0; k < 6; k++) begin
                r = $random(seed);
                drive_add(r[4:0], (r[9:5] == '0) ? 5'd2 : r[9:5], r[14:10],
                          $random(seed), $random(seed));
                i_immediate = {{16{r[31]}}, r[31:16]};
                i_opcode = ops[k];
                i_ctrl = make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, mips_ex_pkg::I_TYPE,
                                   2'b00, 1'b0);
                step("i_type");
            end
        end
        end_test("i_type");
    endtask

    task automatic load_store_addr();
        logic [31:0] r;
        for (int rep = 0; rep < REPS; rep++) begin
            r = $random(seed);
            drive_add(r[4:0], r[9:5], r[14:10], $random(seed), $random(seed));
            i_immediate = {{16{r[31]}}, r[31:16]};
            i_opcode = 6'b100011;   // lw
            i_ctrl = make_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, mips_ex_pkg::LOAD_STORE,
                               2'b11, 1'b1);
            step("load");
            i_rt = i_rt ^ 5'd1;     // keep the store data clear of the load
            i_reg_db = $random(seed);
            i_opcode = 6'b101011;   // sw
            i_ctrl = make_ctrl(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, mips_ex_pkg::LOAD_STORE,
                               2'b11, 1'b0);
            step("store");
            check_value("store_data", i_reg_db, o_ex_mem.data4mem);
        end
        end_test("load_store");
    endtask

    task automatic forwarding_paths();
        i_ctrl = make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, mips_ex_pkg::BRANCH, 2'b00, 1'b0);
        step("fwd_flush");
        drive_add(5'd1, 5'd2, 5'd5, 32'd100, 32'd23);
        step("fwd_seed");
        drive_add(5'd5, 5'd3, 5'd6, 32'd999, 32'd1);
        step("fwd_exmem");
        check_value("fwd_exmem", 32'd124, o_ex_mem.result);
        i_memwb_reg_write = 1'b1;
        i_memwb_write_reg = 5'd7;
        i_memwb_result = 32'h55;
        drive_add(5'd7, 5'd3, 5'd8, 32'd999, 32'd1);
        step("fwd_memwb");
        check_value("fwd_memwb", 32'h56, o_ex_mem.result);
        i_memwb_write_reg = 5'd8;   // both stages hold r8
        i_memwb_result = 32'h1000;
        drive_add(5'd8, 5'd0, 5'd9, 32'd999, 32'd2);
        step("fwd_priority");
        check_value("fwd_priority", 32'h58, o_ex_mem.result);
        i_memwb_write_reg = 5'd0;
        i_memwb_result = 32'hdead;
        drive_add(5'd1, 5'd2, 5'd0, 32'd10, 32'd20);
        step("fwd_r0_write");
        drive_add(5'd0, 5'd0, 5'd3, 32'd0, 32'd0);
        step("fwd_r0");
        check_value("fwd_r0", 32'd0, o_ex_mem.result);
        i_memwb_reg_write = 1'b0;
        drive_add(5'd1, 5'd2, 5'd4, 32'd10, 32'd20);
        step("fwd_link_seed");
        drive_add(5'd4, 5'd4, 5'd31, 32'h400, 32'd8);
        i_opcode = 6'b000011;       // jal
        i_ctrl = make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, mips_ex_pkg::I_TYPE, 2'b00, 1'b0);
        step("fwd_jal");
        check_value("fwd_jal", 32'h408, o_ex_mem.result);
        drive_add(5'd4, 5'd4, 5'd31, 32'h200, 32'd4);
        i_func = 6'b001001;         // jalr
        step("fwd_jalr");
        check_value("fwd_jalr", 32'h204, o_ex_mem.result);
        end_test("forwarding");
    endtask

    task automatic branch_idle();
        for (int k = 0; k < 2; k++) begin
            drive_add(5'd1, 5'd2, 5'd0, $random(seed), $random(seed));
            i_opcode = 6'b000100;
            i_ctrl = make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, mips_ex_pkg::BRANCH,
                               2'b00, 1'b0);
            step("branch");
            check_value("branch", 32'd0, o_ex_mem.result);
        end
        end_test("branch");
    endtask

    task automatic halt_and_reset();
        drive_add(5'd1, 5'd2, 5'd10, 32'd7, 32'd8);
        step("halt_setup");
        i_halt = 1'b1;
        for (int k = 0; k < 4; k++) begin
            drive_add(5'd10, 5'd10, 5'd11, $random(seed), $random(seed));
            step("halt");
            check_value("halt_result", 32'd15, o_ex_mem.result);
        end
        i_halt = 1'b0;
        drive_add(5'd3, 5'd4, 5'd11, 32'd1, 32'd2);
        i_ctrl.mem_write = 1'b1;
        step("resume");
        i_reset = 1'b1;
        step("mid_reset");
        check_value("mid_reset", 32'd0, {30'b0, o_ex_mem.reg_write, o_ex_mem.mem_write});
        i_reset = 1'b0;
        drive_add(5'd11, 5'd4, 5'd12, 32'd5, 32'd6);
        step("after_reset");
        end_test("halt_reset");
    endtask

    initial begin
        i_reset = 1'b1;
        i_halt = 1'b0;
        drive_add(5'd0, 5'd0, 5'd0, 32'd0, 32'd0);
        i_memwb_reg_write = 1'b0;
        i_memwb_write_reg = '0;
        i_memwb_result = '0;
        prev_exp = '0;
        repeat (10) @(negedge clk);
        i_reset = 1'b0;
        r_type_ops();
        i_type_imm();
        load_store_addr();
        forwarding_paths();
        branch_idle();
        halt_and_reset();
        afails = DUT.u_checker.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", total_checks,
                 total_errors, afails);
        if ((total_errors == 0) && (afails == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
mips_ex_pkg.sv
alu.sv
forwarding_unit.sv
ex_mem_reg.sv
ex_stage.sv
ex_subsystem.sv
ex_subsystem_checker.sv
tb_ex_subsystem.sv

/* Makefile */
TOP := tb_ex_subsystem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | \
		grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
